/* common/opcol_cfg_pkg.sv */
/*
 * Size constants and basic index types for the operand collector.
 * Imported by every RTL module that needs register, warp or bank widths.
 */

package opcol_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Bank count is tied to register bits 4:3.
  localparam int NUM_BANKS     = 4;
  localparam int BANK_W        = 2;
  localparam int REG_W         = 5;
  localparam int WARP_W        = 3;
  localparam int DATA_W        = 32;
  localparam int TAG_W         = 8;

  // Source operand slots per instruction.
  localparam int NUM_SRC       = 3;

  // Storage of one bank is 8 registers for each of 8 warps.
  localparam int NUM_WARPS     = 1 << WARP_W;
  localparam int REGS_PER_BANK = (1 << REG_W) / NUM_BANKS;

  ////////////////////////////////////////////////////////////////////////////
  // Index and value types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [REG_W-1:0]  reg_num_t;
  typedef logic [WARP_W-1:0] warp_num_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [BANK_W-1:0] bank_num_t;

  // Bank select from the upper register bits.
  function automatic bank_num_t bank_of(reg_num_t r);
    return r[4:3];
  endfunction

endpackage

/* common/opcol_instr_pkg.sv */
/*
 * Instruction, read request, writeback and dispatch types.
 * Shared by the issue gate, collectors, arbiter, banks and top level.
 */

package opcol_instr_pkg;

  import opcol_cfg_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    NOP = 3'd0,
    MOV = 3'd1,
    ADD = 3'd2,
    SUB = 3'd3,
    MAD = 3'd4
  } opcode_t;

  // Source slots read by each opcode, slot 0 first.
  function automatic logic [NUM_SRC-1:0] src_needed(opcode_t op);
    case (op)
      MOV:      return 3'b001;
      ADD, SUB: return 3'b011;
      MAD:      return 3'b111;
      default:  return 3'b000;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Transfer structs
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    tag_t                    tag;
    warp_num_t               warp;
    opcode_t                 opcode;
    reg_num_t [NUM_SRC-1:0]  src;
    reg_num_t                dst;
  } instr_t;

  // Also used for the per-bank read port.
  typedef struct packed {
    logic      valid;
    warp_num_t warp;
    reg_num_t  reg_num;
  } rd_req_t;

  typedef struct packed {
    logic      valid;
    warp_num_t warp;
    reg_num_t  reg_num;
    data_t     data;
  } wb_t;

  typedef struct packed {
    tag_t                 tag;
    warp_num_t            warp;
    opcode_t              opcode;
    reg_num_t             dst;
    data_t [NUM_SRC-1:0]  opnd;
  } dispatch_t;

endpackage

/* rtl/opcol_issue_gate.sv */
/*
 * Issue gate. Loads each issued instruction into the lowest free collector
 * and returns an issue credit whenever a collector becomes free again.
 */

`timescale 1ns/1ps

module opcol_issue_gate
  import opcol_cfg_pkg::*;
  import opcol_instr_pkg::*;
#(
  parameter int NUM_COLLECTORS = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      issue_valid,
  input  instr_t                    issue_instr,
  input  logic [NUM_COLLECTORS-1:0] collector_free,
  output logic [NUM_COLLECTORS-1:0] load,
  output instr_t                    load_instr,
  output logic                      issue_credit
);

  // Free mask seen last cycle.
  logic [NUM_COLLECTORS-1:0] free_q;
  logic                      found;

  ////////////////////////////////////////////////////////////////////////////
  // Collector selection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    load  = '0;
    found = 1'b0;
    if (issue_valid) begin
      for (int c = 0; c < NUM_COLLECTORS; c++) begin
        if (!found && collector_free[c]) begin
          load[c] = 1'b1;
          found   = 1'b1;
        end
      end
    end
  end

  assign load_instr = issue_instr;

  ////////////////////////////////////////////////////////////////////////////
  // Credit return
  ////////////////////////////////////////////////////////////////////////////

  // A collector that just went free hands one credit back.
  // Loading makes the bit fall, which returns nothing.
  always_ff @(posedge clk) begin
    if (rst_n) begin
      free_q <= '1;
    end else begin
      free_q <= collector_free;
    end
  end

  assign issue_credit = |(collector_free & ~free_q);

  // The issuer only sends while it holds a credit, so a slot must be open.
  a_issue_has_slot: assert property (
    @(posedge clk) disable iff (rst_n)
    issue_valid |-> (collector_free != '0)
  ) else $error("issue arrived with no free collector");

endmodule

/* collector/collector_unit.sv */
/*
 * One operand collector entry. Requests the source registers of its
 * instruction, gathers the read data and holds the instruction until the
 * top level takes it for dispatch.
 */

`timescale 1ns/1ps

module collector_unit
  import opcol_cfg_pkg::*;
  import opcol_instr_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        load,
  input  instr_t                      load_instr,
  output rd_req_t [NUM_SRC-1:0]       rd_req,
  input  logic [NUM_SRC-1:0]          grant,
  input  data_t [NUM_SRC-1:0]         rd_data,
  input  logic [NUM_SRC-1:0]          rd_data_valid,
  output logic                        ready,
  input  logic                        dispatch_take,
  output dispatch_t                   dispatch,
  output logic                        free
);

  typedef enum logic [1:0] {
    FREE,
    COLLECT,
    READY
  } state_t;

  state_t               state;
  instr_t               instr_q;
  data_t [NUM_SRC-1:0]  opnd;

  // Per-slot flags for pending request, pending data and captured data.
  logic [NUM_SRC-1:0]   req_pend;
  logic [NUM_SRC-1:0]   wait_data;
  logic [NUM_SRC-1:0]   have;
  logic [NUM_SRC-1:0]   have_next;
  logic [NUM_SRC-1:0]   need_in;

  assign need_in   = src_needed(load_instr.opcode);
  assign have_next = have | (rd_data_valid & wait_data);

  ////////////////////////////////////////////////////////////////////////////
  // Slot tracking and state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state     <= FREE;
      req_pend  <= '0;
      wait_data <= '0;
      have      <= '0;
    end else begin
      case (state)
        FREE: begin
          if (load) begin
            req_pend  <= need_in;
            wait_data <= '0;
            // Unused slots count as already present.
            have      <= ~need_in;
            state     <= (need_in == '0) ? READY : COLLECT;
          end
        end
        COLLECT: begin
          req_pend  <= req_pend & ~grant;
          wait_data <= (wait_data & ~rd_data_valid) | (req_pend & grant);
          have      <= have_next;
          if (&have_next) begin
            state <= READY;
          end
        end
        READY: begin
          if (dispatch_take) begin
            state <= FREE;
          end
        end
        default: state <= FREE;
      endcase
    end
  end

  // Instruction and operand values.
  always_ff @(posedge clk) begin
    if (state == FREE && load) begin
      instr_q <= load_instr;
      opnd    <= '0;
    end else begin
      for (int i = 0; i < NUM_SRC; i++) begin
        if (rd_data_valid[i]) begin
          opnd[i] <= rd_data[i];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NUM_SRC; i++) begin
      rd_req[i].valid   = (state == COLLECT) && req_pend[i];
      rd_req[i].warp    = instr_q.warp;
      rd_req[i].reg_num = instr_q.src[i];
    end
  end

  assign ready = (state == READY);
  assign free  = (state == FREE);

  always_comb begin
    dispatch.tag    = instr_q.tag;
    dispatch.warp   = instr_q.warp;
    dispatch.opcode = instr_q.opcode;
    dispatch.dst    = instr_q.dst;
    dispatch.opnd   = opnd;
  end

  // Data routed from the banks must match a grant from the previous cycle.
  a_data_after_grant: assert property (
    @(posedge clk) disable iff (rst_n)
    (rd_data_valid & ~wait_data) == '0
  ) else $error("read data for a slot with no grant pending");

endmodule

/* arbiter/bank_arbiter.sv */
/*
 * Bank arbiter. Each bank grants at most one collector read per cycle,
 * with round-robin priority among collectors, and remembers the grant so
 * the next cycle's bank data reaches the right slot.
 */

`timescale 1ns/1ps

module bank_arbiter
  import opcol_cfg_pkg::*;
  import opcol_instr_pkg::*;
#(
  parameter int NUM_COLLECTORS = 4
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  rd_req_t [NUM_COLLECTORS*NUM_SRC-1:0] rd_req,
  output logic [NUM_COLLECTORS*NUM_SRC-1:0]    grant,
  output rd_req_t [NUM_BANKS-1:0]              bank_rd,
  output logic [NUM_COLLECTORS*NUM_SRC-1:0]    data_route
);

  localparam int NUM_SLOTS = NUM_COLLECTORS * NUM_SRC;
  localparam int CW        = (NUM_COLLECTORS > 1) ? $clog2(NUM_COLLECTORS) : 1;

  // Collector that holds top priority on each bank.
  logic [CW-1:0]          rr_ptr  [NUM_BANKS];
  logic [CW-1:0]          win_col [NUM_BANKS];
  logic [NUM_BANKS-1:0]   bank_hit;
  logic [NUM_SLOTS-1:0]   grant_by_bank [NUM_BANKS];

  ////////////////////////////////////////////////////////////////////////////
  // Per-bank selection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    int c;
    int slot;
    grant    = '0;
    bank_hit = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      win_col[b] = '0;
      bank_rd[b] = '0;
      // Walk collectors from the pointer; slots inside one go lowest first.
      for (int k = 0; k < NUM_COLLECTORS; k++) begin
        c = int'(rr_ptr[b]) + k;
        if (c >= NUM_COLLECTORS) begin
          c = c - NUM_COLLECTORS;
        end
        for (int s = 0; s < NUM_SRC; s++) begin
          slot = c * NUM_SRC + s;
          if (!bank_hit[b] && rd_req[slot].valid &&
              bank_of(rd_req[slot].reg_num) == bank_num_t'(b)) begin
            bank_hit[b] = 1'b1;
            win_col[b]  = CW'(c);
            grant[slot] = 1'b1;
            bank_rd[b]  = rd_req[slot];
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and data routing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_n) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        rr_ptr[b] <= '0;
      end
      data_route <= '0;
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (bank_hit[b]) begin
          rr_ptr[b] <= (int'(win_col[b]) == NUM_COLLECTORS - 1) ? '0 : win_col[b] + 1'b1;
        end
      end
      // Bank data comes back next cycle.
      data_route <= grant;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Grants sorted by the bank of the granted register.
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
        grant_by_bank[b][s] = grant[s] && (bank_of(rd_req[s].reg_num) == bank_num_t'(b));
      end
    end
  end

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank_chk
    a_one_grant_per_bank: assert property (
      @(posedge clk) disable iff (rst_n)
      $onehot0(grant_by_bank[b])
    ) else $error("bank %0d granted more than one read", b);
  end

  // A collector keeps its request up until the arbiter grants it.
  for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_slot_chk
    a_req_held: assert property (
      @(posedge clk) disable iff (rst_n)
      rd_req[s].valid && !grant[s] |=> rd_req[s].valid
    ) else $error("slot %0d dropped its request before a grant", s);
  end

endmodule

/* rtl/register_banks.sv */
/*
 * Banked register file. Four banks, each with one registered read port,
 * and one writeback port that lands in the bank of its register.
 */

`timescale 1ns/1ps

module register_banks
  import opcol_cfg_pkg::*;
  import opcol_instr_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  rd_req_t [NUM_BANKS-1:0]  bank_rd,
  input  wb_t                      wb,
  output data_t [NUM_BANKS-1:0]    bank_data
);

  localparam int DEPTH = NUM_WARPS * REGS_PER_BANK;
  localparam int IDX_W = $clog2(DEPTH);

  logic [IDX_W-1:0] wb_idx;

  // Row within a bank is warp number over the low register bits.
  assign wb_idx = {wb.warp, wb.reg_num[2:0]};

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    data_t            mem [DEPTH];
    logic [IDX_W-1:0] rd_idx;

    assign rd_idx = {bank_rd[b].warp, bank_rd[b].reg_num[2:0]};

    // Write.
    always_ff @(posedge clk) begin
      if (wb.valid && bank_of(wb.reg_num) == bank_num_t'(b)) begin
        mem[wb_idx] <= wb.data;
      end
    end

    // A read in the same cycle as a write to that row sees the old value.
    always_ff @(posedge clk) begin
      if (rst_n) begin
        bank_data[b] <= '0;
      end else if (bank_rd[b].valid) begin
        bank_data[b] <= mem[rd_idx];
      end
    end
  end

endmodule

/* rtl/opcol_top.sv */
/*
 * Operand collector top level. Connects the issue gate, the collectors,
 * the bank arbiter and the register banks, and picks one ready collector
 * per cycle for dispatch under downstream credit.
 */

`timescale 1ns/1ps

module opcol_top
  import opcol_cfg_pkg::*;
  import opcol_instr_pkg::*;
#(
  parameter int NUM_COLLECTORS   = 4,
  parameter int DISPATCH_CREDITS = 2
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      issue_valid,
  input  instr_t    issue_instr,
  output logic      issue_credit,
  input  wb_t       wb,
  output logic      dispatch_valid,
  output dispatch_t dispatch,
  input  logic      dispatch_credit
);

  localparam int NUM_SLOTS = NUM_COLLECTORS * NUM_SRC;
  localparam int CW        = (NUM_COLLECTORS > 1) ? $clog2(NUM_COLLECTORS) : 1;
  localparam int CNT_W     = $clog2(DISPATCH_CREDITS + 1);

  logic [NUM_COLLECTORS-1:0]       coll_free;
  logic [NUM_COLLECTORS-1:0]       coll_ready;
  logic [NUM_COLLECTORS-1:0]       load;
  logic [NUM_COLLECTORS-1:0]       take;
  instr_t                          load_instr;
  dispatch_t [NUM_COLLECTORS-1:0]  coll_disp;
  rd_req_t [NUM_SLOTS-1:0]         coll_req;
  logic [NUM_SLOTS-1:0]            grant;
  logic [NUM_SLOTS-1:0]            data_route;
  data_t [NUM_SLOTS-1:0]           slot_data;
  rd_req_t [NUM_BANKS-1:0]         bank_rd;
  data_t [NUM_BANKS-1:0]           bank_data;
  logic [CW-1:0]                   sel;
  logic                            found;
  logic [CNT_W-1:0]                credit_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////////////////////

  opcol_issue_gate #(
    .NUM_COLLECTORS (NUM_COLLECTORS)
  ) u_gate (
    .clk            (clk),
    .rst_n          (rst_n),
    .issue_valid    (issue_valid),
    .issue_instr    (issue_instr),
    .collector_free (coll_free),
    .load           (load),
    .load_instr     (load_instr),
    .issue_credit   (issue_credit)
  );

  for (genvar c = 0; c < NUM_COLLECTORS; c++) begin : g_coll
    collector_unit u_coll (
      .clk           (clk),
      .rst_n         (rst_n),
      .load          (load[c]),
      .load_instr    (load_instr),
      .rd_req        (coll_req[c*NUM_SRC +: NUM_SRC]),
      .grant         (grant[c*NUM_SRC +: NUM_SRC]),
      .rd_data       (slot_data[c*NUM_SRC +: NUM_SRC]),
      .rd_data_valid (data_route[c*NUM_SRC +: NUM_SRC]),
      .ready         (coll_ready[c]),
      .dispatch_take (take[c]),
      .dispatch      (coll_disp[c]),
      .free          (coll_free[c])
    );
  end

  bank_arbiter #(
    .NUM_COLLECTORS (NUM_COLLECTORS)
  ) u_arb (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_req     (coll_req),
    .grant      (grant),
    .bank_rd    (bank_rd),
    .data_route (data_route)
  );

  register_banks u_banks (
    .clk       (clk),
    .rst_n     (rst_n),
    .bank_rd   (bank_rd),
    .wb        (wb),
    .bank_data (bank_data)
  );

  // The slot's register still names its bank after the grant.
  always_comb begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      slot_data[s] = bank_data[bank_of(coll_req[s].reg_num)];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Dispatch
  ////////////////////////////////////////////////////////////////////////////

  // Lowest ready collector wins while a credit is held.
  always_comb begin
    take  = '0;
    sel   = '0;
    found = 1'b0;
    for (int c = 0; c < NUM_COLLECTORS; c++) begin
      if (!found && coll_ready[c] && credit_cnt != '0) begin
        take[c] = 1'b1;
        sel     = CW'(c);
        found   = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      dispatch_valid <= 1'b0;
      credit_cnt     <= CNT_W'(DISPATCH_CREDITS);
    end else begin
      dispatch_valid <= found;
      case ({found, dispatch_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (found) begin
      dispatch <= coll_disp[sel];
    end
  end

endmodule

/* tb/opcol_tb.sv */
/*
 * Testbench for the operand collector top level. Replays the trace file,
 * keeps a register model and checks every dispatch against it by tag.
 */

`timescale 1ns/1ps

module opcol_tb
  import opcol_cfg_pkg::*;
  import opcol_instr_pkg::*;
();

  localparam int NUM_COLLECTORS   = 4;
  localparam int DISPATCH_CREDITS = 2;
  localparam int CYCLES_PER_LINE  = 200;

  logic      clk;
  logic      rst_n;
  logic      issue_valid;
  instr_t    issue_instr;
  logic      issue_credit;
  wb_t       wb;
  logic      dispatch_valid;
  dispatch_t dispatch;
  logic      dispatch_credit;

  // Register model and per-tag expectations.
  data_t     reg_model [NUM_WARPS][1 << REG_W];
  logic      issued [256];
  logic      done [256];
  dispatch_t expect_disp [256];

  string       trace_lines [$];
  logic        trace_loaded;
  int          errors;
  int          checks;
  int          issue_credits;
  int          issued_total;
  int          credits_back;
  int          dispatched_total;
  int          outstanding;
  int          credit_pend;
  int          credit_delay;
  int          credits_returned;
  logic [31:0] rnd_state;

  opcol_top #(
    .NUM_COLLECTORS   (NUM_COLLECTORS),
    .DISPATCH_CREDITS (DISPATCH_CREDITS)
  ) u_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .issue_valid     (issue_valid),
    .issue_instr     (issue_instr),
    .issue_credit    (issue_credit),
    .wb              (wb),
    .dispatch_valid  (dispatch_valid),
    .dispatch        (dispatch),
    .dispatch_credit (dispatch_credit)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Number of sources each opcode reads.
  function automatic int sources_of(int op);
    case (op)
      1:       return 1;
      2, 3:    return 2;
      4:       return 3;
      default: return 0;
    endcase
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Watches the outputs once per cycle on the falling edge.
  task automatic sample_outputs();
    dispatch_t exp_d;
    if (issue_credit) begin
      issue_credits++;
      credits_back++;
    end
    if (dispatch_valid) begin
      dispatched_total++;
      credit_pend++;
      checks++;
      if (dispatched_total > credits_returned + DISPATCH_CREDITS) begin
        errors++;
        $display("dispatch at %0t went out with no credit left", $time);
      end
      checks++;
      if (!issued[dispatch.tag]) begin
        errors++;
        $display("tag %h dispatched but was never issued", dispatch.tag);
      end else if (done[dispatch.tag]) begin
        errors++;
        $display("tag %h dispatched more than once", dispatch.tag);
      end else begin
        done[dispatch.tag] = 1'b1;
        outstanding--;
        exp_d = expect_disp[dispatch.tag];
        check_value("dispatch.warp", 32'(dispatch.warp), 32'(exp_d.warp));
        check_value("dispatch.opcode", 32'(dispatch.opcode), 32'(exp_d.opcode));
        check_value("dispatch.dst", 32'(dispatch.dst), 32'(exp_d.dst));
        for (int i = 0; i < NUM_SRC; i++) begin
          check_value($sformatf("dispatch.opnd[%0d]", i), dispatch.opnd[i],
                      exp_d.opnd[i]);
        end
      end
    end
  endtask

  // Consumer model. One credit back per dispatch after a random delay.
  task automatic return_credit();
    dispatch_credit = 1'b0;
    if (credit_pend > 0) begin
      if (credit_delay == 0) begin
        dispatch_credit = 1'b1;
        credit_pend--;
        credits_returned++;
        rnd_state    = xorshift32(rnd_state);
        credit_delay = int'(rnd_state[2:0]);
      end else begin
        credit_delay--;
      end
    end
  endtask

  task automatic tick();
    @(negedge clk);
    sample_outputs();
    return_credit();
    issue_valid = 1'b0;
    wb.valid    = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Trace replay
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_line(string line);
    byte         kind;
    int          n;
    logic [31:0] v0, v1, v2, v3, v4, v5, v6;
    reg_num_t    src [NUM_SRC];
    dispatch_t   exp_d;
    if (line.len() == 0) begin
      return;
    end
    kind = line.getc(0);
    case (kind)
      "W": begin
        n = $sscanf(line, "%c %h %h %h", kind, v0, v1, v2);
        if (n != 4) begin
          errors++;
          $display("bad writeback line in trace: %s", line);
        end else begin
          tick();
          wb.valid   = 1'b1;
          wb.warp    = v0[2:0];
          wb.reg_num = v1[4:0];
          wb.data    = v2;
          reg_model[v0[2:0]][v1[4:0]] = v2;
        end
      end
      "I": begin
        n = $sscanf(line, "%c %h %h %h %h %h %h %h", kind, v0, v1, v2, v3, v4, v5, v6);
        if (n != 8) begin
          errors++;
          $display("bad instruction line in trace: %s", line);
        end else begin
          src[0] = v4[4:0];
          src[1] = v5[4:0];
          src[2] = v6[4:0];
          // Issue only while holding a credit.
          tick();
          while (issue_credits == 0) begin
            tick();
          end
          issue_valid        = 1'b1;
          issue_instr.tag    = v0[7:0];
          issue_instr.warp   = v1[2:0];
          issue_instr.opcode = opcode_t'(v2[2:0]);
          issue_instr.dst    = v3[4:0];
          for (int i = 0; i < NUM_SRC; i++) begin
            issue_instr.src[i] = src[i];
          end
          issue_credits--;
          issued_total++;
          outstanding++;
          // Operand values as they stand when the instruction issues.
          exp_d        = '0;
          exp_d.tag    = v0[7:0];
          exp_d.warp   = v1[2:0];
          exp_d.opcode = opcode_t'(v2[2:0]);
          exp_d.dst    = v3[4:0];
          for (int i = 0; i < sources_of(int'(v2)); i++) begin
            exp_d.opnd[i] = reg_model[v1[2:0]][src[i]];
          end
          expect_disp[v0[7:0]] = exp_d;
          issued[v0[7:0]]      = 1'b1;
          done[v0[7:0]]        = 1'b0;
        end
      end
      "D": begin
        while (outstanding > 0) begin
          tick();
        end
        checks++;
        if (credits_back != issued_total) begin
          errors++;
          $display("after drain %0d issue credits came back for %0d instructions",
                   credits_back, issued_total);
        end
      end
      "#", " ", "\n", "\r": begin
      end
      default: begin
        errors++;
        $display("unknown command in trace: %s", line);
      end
    endcase
  endtask

  task automatic load_trace();
    int    fd;
    string line;
    fd = $fopen("tb/opcol_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open the trace file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          trace_lines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n            = 1'b1;
    issue_valid      = 1'b0;
    issue_instr      = '0;
    wb               = '0;
    dispatch_credit  = 1'b0;
    trace_loaded     = 1'b0;
    errors           = 0;
    checks           = 0;
    issue_credits    = NUM_COLLECTORS;
    issued_total     = 0;
    credits_back     = 0;
    dispatched_total = 0;
    outstanding      = 0;
    credit_pend      = 0;
    credits_returned = 0;
    rnd_state        = 32'h9b19_7931;
    credit_delay     = 0;
    for (int t = 0; t < 256; t++) begin
      issued[t] = 1'b0;
      done[t]   = 1'b0;
    end
    for (int w = 0; w < NUM_WARPS; w++) begin
      for (int r = 0; r < (1 << REG_W); r++) begin
        reg_model[w][r] = '0;
      end
    end
    load_trace();
    trace_loaded = 1'b1;

    repeat (5) @(posedge clk);
    @(negedge clk);
    checks++;
    if (issue_credit !== 1'b0 || dispatch_valid !== 1'b0) begin
      errors++;
      $display("issue_credit or dispatch_valid not low during reset");
    end
    rst_n = 1'b0;

    foreach (trace_lines[i]) begin
      run_line(trace_lines[i]);
    end

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    wait (trace_loaded);
    repeat ((trace_lines.size() + 1) * CYCLES_PER_LINE + 10) @(posedge clk);
    $display("watchdog expired before the trace finished");
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* gpu_opcol.f */
common/opcol_cfg_pkg.sv
common/opcol_instr_pkg.sv
rtl/opcol_issue_gate.sv
collector/collector_unit.sv
arbiter/bank_arbiter.sv
rtl/register_banks.sv
rtl/opcol_top.sv
tb/opcol_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the operand collector testbench with Verilator, run it, check the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module opcol_tb -f gpu_opcol.f \
  -o opcol_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/opcol_sim > sim.log 2>&1
cat sim.log
grep -q '^>>> PASS$' sim.log && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}

/* tb/opcol_trace.txt */
# Operand collector trace. Fields are hex, one command per line.
# W warp reg data | I tag warp opcode dst src0 src1 src2 | D drain
# Opcodes: 0 NOP, 1 MOV, 2 ADD, 3 SUB, 4 MAD. Bank is reg bits 4:3.
W 0 01 a0000001
W 0 02 a0000002
W 0 0a a000000a
W 0 12 a0000012
W 0 1b a000001b
W 1 03 b1000003
W 1 0b b100000b
W 1 13 b1000013
W 1 1c b100001c
W 5 04 c5000004
W 5 05 c5000005
W 5 06 c5000006
W 7 0e d700000e
# Sources in different banks, then MOV and NOP
I 01 0 2 07 01 0a 00
I 02 1 3 07 03 13 00
I 03 0 1 08 12 1b 1b
I 04 0 0 09 01 02 0a
D
# Sources sharing one bank
I 05 0 2 09 01 02 00
I 06 5 4 07 04 05 06
I 07 1 4 10 0b 0b 1c
D
# Collectors contending for bank 1, more instructions than collectors
I 08 0 1 10 0a 00 00
I 09 1 1 11 0b 00 00
I 0a 7 2 12 0e 0e 00
I 0b 0 4 13 0a 02 12
I 0c 1 3 14 0b 13 03
I 0d 7 1 15 0e 00 00
D
# New values, read right after the writes
W 0 0a 0000aaaa
W 7 0e 0000eeee
W 5 1f c500001f
I 0e 0 2 16 0a 01 00
I 0f 7 4 17 0e 0e 0e
I 10 5 3 18 1f 06 00
I 11 0 0 19 00 00 00
D
